/* alu/alu.sv */
`default_nettype none

module alu (
    input  mips_isa_pkg::word_t    op_a,
    input  mips_isa_pkg::word_t    op_b,
    input  mips_isa_pkg::instr_t   instr,
    output mips_cpu_pkg::alu_out_t out
);
    import mips_isa_pkg::*;

    word_t       imm_sext;
    word_t       imm_zext;
    word_t       result;
    logic [63:0] product;
    logic        operands_equal;

    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {16'h0000, instr.i.imm};

    // low 64 bits of a widened product, sign- or zero-extended inputs
    always_comb begin
        if (instr.r.funct == fn_multu) begin
            product = {32'h0, op_a} * {32'h0, op_b};
        end else begin
            product = {{32{op_a[31]}}, op_a} * {{32{op_b[31]}}, op_b};
        end
    end

    always_comb begin
        result = '0;
        case (instr.r.opcode)
            op_special: begin
                case (instr.r.funct)
                    fn_sll:  result = op_b << instr.r.shamt;
                    fn_srl:  result = op_b >> instr.r.shamt;
                    fn_sra:  result = $signed(op_b) >>> instr.r.shamt;
                    fn_addu: result = op_a + op_b;
                    fn_subu: result = op_a - op_b;
                    fn_and:  result = op_a & op_b;
                    fn_or:   result = op_a | op_b;
                    fn_xor:  result = op_a ^ op_b;
                    fn_nor:  result = ~(op_a | op_b);
                    fn_slt:  result = {31'b0, $signed(op_a) < $signed(op_b)};
                    fn_sltu: result = {31'b0, op_a < op_b};
                    default: result = '0;
                endcase
            end
            op_addiu: result = op_a + imm_sext;
            op_slti:  result = {31'b0, $signed(op_a) < $signed(imm_sext)};
            // sltiu still sign-extends, then compares unsigned
            op_sltiu: result = {31'b0, op_a < imm_sext};
            op_andi:  result = op_a & imm_zext;
            op_ori:   result = op_a | imm_zext;
            op_xori:  result = op_a ^ imm_zext;
            op_lui:   result = {instr.i.imm, 16'h0000};
            default:  result = '0;
        endcase
    end

    assign operands_equal = (op_a == op_b);

    assign out = '{
        result:       result,
        lo:           product[31:0],
        hi:           product[63:32],
        eff_addr:     op_a + imm_sext,
        branch_taken: (instr.i.opcode == op_beq && operands_equal) ||
                      (instr.i.opcode == op_bne && !operands_equal)
    };

endmodule

`default_nettype wire

/* bench/mips_cpu_asserts.sv */
`default_nettype none

module mips_cpu_asserts (
    input logic                   clk,
    input logic                   reset,
    input logic                   clk_enable,
    input logic                   active,
    input logic                   data_read,
    input logic                   data_write,
    input mips_isa_pkg::word_t    instr_address,
    input mips_isa_pkg::instr_t   instr,
    input mips_cpu_pkg::alu_out_t alu_out
);
    timeunit 1ns;
    timeprecision 100ps;

    import mips_isa_pkg::*;

    int   failures = 0;
    logic access_aligned;

    // natural alignment for the width of the access
    always_comb begin
        case (instr.i.opcode)
            op_lw, op_sw:         access_aligned = (alu_out.eff_addr[1:0] == 2'b00);
            op_lh, op_lhu, op_sh: access_aligned = !alu_out.eff_addr[0];
            default:              access_aligned = 1'b1;
        endcase
    end

    // an enabled reset edge leaves the core in fetch, so no store follows
    no_store_after_reset: assert property (
        @(posedge clk) (reset && clk_enable) |=> !data_write
    ) else begin
        failures++;
        $error("data_write high right after a reset edge");
    end

    // fetch address stays on a word boundary while running
    fetch_aligned: assert property (
        @(posedge clk) disable iff (reset) active |-> (instr_address[1:0] == 2'b00)
    ) else begin
        failures++;
        $error("instr_address not word aligned");
    end

    data_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (data_read || data_write) |-> access_aligned
    ) else begin
        failures++;
        $error("misaligned data access at effective address %h", alu_out.eff_addr);
    end

endmodule

bind mips_cpu_harvard mips_cpu_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .clk_enable    (clk_enable),
    .active        (active),
    .data_read     (data_read),
    .data_write    (data_write),
    .instr_address (instr_address),
    .instr         (instr),
    .alu_out       (alu_out)
);

`default_nettype wire

/* bench/program_vectors.hex */
// one 32-bit word per line: 0-31 program from bfc00000, 32-39 data at 1000,
// 40 expected register_v0, 41-48 expected data words at 1000-101c
// setup, mult and multu
24081000
3C091234
35295678
8D0A0018
012A0018
00005812
012A0019
AD0B0000
00006010
AD0C0004
81020011
950D0012
// beq, bne, j, jal, jalr with delay slots and skipped words
10000002
910E0014
24420100
15000002
A50D001E
24420200
0BF00015
A10E000D
24420400
0FF00018
27F90014
24420800
850F0010
0320F809
004F1021
24421000
005F1021
00021103
00000008
00000000
// initial data
00000000
00000000
DEADBEEF
11223344
80F1A2B3
9C000000
FFFFFFFD
CAFEBABE
// expected register_v0
FBFBF814
// expected data
C962FC98
12345677
DEADBEEF
119C3344
80F1A2B3
9C000000
FFFFFFFD
CAFEA2B3

/* bench/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

`default_nettype wire

/* bench/tb_mips.sv */
`default_nettype none

module tb_mips;
    timeunit 1ns;
    timeprecision 100ps;

    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;

    localparam word_t data_base = 32'h0000_1000;
    localparam word_t seed      = 32'hbf2e_495f;

    logic  clk;
    logic  reset;
    logic  clk_enable;
    word_t instr_readdata;
    word_t data_readdata;
    logic  active;
    logic  data_read;
    logic  data_write;
    word_t register_v0;
    word_t instr_address;
    word_t data_address;
    word_t data_writedata;

    // 0-31 program, 32-39 data, 40 expected v0, 41-48 expected data
    word_t vectors [49];
    word_t dmem [8];
    word_t rng;
    int    errors;
    int    stray_stores;

    tb_clock clock_gen (.clk(clk));

    mips_cpu_harvard dut (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .instr_readdata (instr_readdata),
        .data_readdata  (data_readdata),
        .active         (active),
        .data_read      (data_read),
        .data_write     (data_write),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .data_address   (data_address),
        .data_writedata (data_writedata)
    );

    function automatic word_t xorshift32(input word_t state);
        word_t x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // unloaded words, unique to each address
    function automatic word_t fill_pattern(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t program_word(input word_t addr);
        word_t offset;
        offset = addr - reset_vector;
        if (offset < 32'd128) begin
            return vectors[int'(offset >> 2)];
        end
        // nop at the halt address so the halt executes cleanly
        if (addr == halt_address) begin
            return 32'h0000_0000;
        end
        return fill_pattern(addr);
    endfunction

    function automatic word_t data_word(input word_t addr);
        if (addr[31:5] == data_base[31:5]) begin
            return dmem[addr[4:2]];
        end
        return fill_pattern(addr);
    endfunction

    always_comb begin
        instr_readdata = program_word(instr_address);
    end

    // the addressed word shows only while a strobe is up
    always_comb begin
        if (data_read || data_write) begin
            data_readdata = data_word(data_address);
        end else begin
            data_readdata = fill_pattern(data_address);
        end
    end

    // data memory, written on enabled edges only
    initial begin
        stray_stores = 0;
        $readmemh("bench/program_vectors.hex", vectors);
        for (int i = 0; i < 8; i++) begin
            dmem[i] <= vectors[32 + i];
        end
        forever begin
            @(posedge clk);
            if (clk_enable && data_write) begin
                if (data_address[31:5] == data_base[31:5]) begin
                    dmem[data_address[4:2]] <= data_writedata;
                end else begin
                    stray_stores++;
                    $display("store outside data memory at address %h", data_address);
                end
            end
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, expected);
        end
    endtask

    initial begin
        int cycles;
        int stalls;
        errors     = 0;
        rng        = seed;
        reset      = 1'b1;
        clk_enable = 1'b1;

        repeat (16) begin
            @(posedge clk);
            #1;
        end
        check_word("instr_address", instr_address, reset_vector);
        check_flag("active", active, 1'b1);
        check_flag("data_write", data_write, 1'b0);
        reset = 1'b0;

        // stalled cycles do not count toward the limit
        cycles = 0;
        stalls = 0;
        while (active && cycles < 2000 && stalls < 2000) begin
            @(posedge clk);
            #1;
            rng        = xorshift32(rng);
            clk_enable = (rng[2:0] != 3'd0);
            if (clk_enable) begin
                cycles++;
            end else begin
                stalls++;
            end
        end
        if (active) begin
            errors++;
            $display("timeout waiting for active to fall");
        end

        // core must stay halted and quiet
        repeat (20) begin
            @(posedge clk);
            #1;
            rng        = xorshift32(rng);
            clk_enable = (rng[2:0] != 3'd0);
            check_flag("active", active, 1'b0);
            check_flag("data_write", data_write, 1'b0);
        end

        check_word("register_v0", register_v0, vectors[40]);
        for (int i = 0; i < 8; i++) begin
            check_word($sformatf("dmem[%h]", data_base + word_t'(4 * i)), dmem[i],
                       vectors[41 + i]);
        end

        $display("check errors: %0d, stray stores: %0d, assertion failures: %0d",
                 errors, stray_stores, dut.u_asserts.failures);
        if (errors == 0 && stray_stores == 0 && dut.u_asserts.failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/mips_cpu_pkg.sv */
`default_nettype none

package mips_cpu_pkg;

    // first fetch after reset
    localparam mips_isa_pkg::word_t reset_vector = 32'hBFC0_0000;

    // executing the word at this address ends the program
    localparam mips_isa_pkg::word_t halt_address = 32'h0000_0000;

    typedef struct packed {
        mips_isa_pkg::word_t result;
        mips_isa_pkg::word_t lo;
        mips_isa_pkg::word_t hi;
        mips_isa_pkg::word_t eff_addr;
        logic                branch_taken;
    } alu_out_t;

endpackage

`default_nettype wire

/* common/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // one instruction word, seen through each encoding
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lh      = 6'h21;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_lhu     = 6'h25;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sh      = 6'h29;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct codes under op_special
    localparam logic [5:0] fn_sll   = 6'h00;
    localparam logic [5:0] fn_srl   = 6'h02;
    localparam logic [5:0] fn_sra   = 6'h03;
    localparam logic [5:0] fn_jr    = 6'h08;
    localparam logic [5:0] fn_jalr  = 6'h09;
    localparam logic [5:0] fn_mfhi  = 6'h10;
    localparam logic [5:0] fn_mflo  = 6'h12;
    localparam logic [5:0] fn_mult  = 6'h18;
    localparam logic [5:0] fn_multu = 6'h19;
    localparam logic [5:0] fn_addu  = 6'h21;
    localparam logic [5:0] fn_subu  = 6'h23;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_xor   = 6'h26;
    localparam logic [5:0] fn_nor   = 6'h27;
    localparam logic [5:0] fn_slt   = 6'h2a;
    localparam logic [5:0] fn_sltu  = 6'h2b;

endpackage

`default_nettype wire

/* filelist.f */
common/mips_isa_pkg.sv
common/mips_cpu_pkg.sv
logic/regfile.sv
alu/alu.sv
logic/mem_align.sv
logic/mips_cpu_harvard.sv
bench/tb_clock.sv
bench/mips_cpu_asserts.sv
bench/tb_mips.sv

/* logic/mem_align.sv */
`default_nettype none

module mem_align (
    input  mips_isa_pkg::instr_t instr,
    input  mips_isa_pkg::word_t  eff_addr,
    input  mips_isa_pkg::word_t  mem_word,
    input  mips_isa_pkg::word_t  store_word,
    output mips_isa_pkg::word_t  load_data,
    output mips_isa_pkg::word_t  write_data
);
    import mips_isa_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // big-endian lanes, offset 0 is the top byte
    always_comb begin
        case (eff_addr[1:0])
            2'd0:    byte_sel = mem_word[31:24];
            2'd1:    byte_sel = mem_word[23:16];
            2'd2:    byte_sel = mem_word[15:8];
            default: byte_sel = mem_word[7:0];
        endcase
        half_sel = eff_addr[1] ? mem_word[15:0] : mem_word[31:16];
    end

    always_comb begin
        case (instr.i.opcode)
            op_lb:   load_data = {{24{byte_sel[7]}}, byte_sel};
            op_lbu:  load_data = {24'h0, byte_sel};
            op_lh:   load_data = {{16{half_sel[15]}}, half_sel};
            op_lhu:  load_data = {16'h0, half_sel};
            op_lw:   load_data = mem_word;
            default: load_data = mem_word;
        endcase
    end

    // partial stores overwrite only the addressed lanes
    always_comb begin
        write_data = mem_word;
        case (instr.i.opcode)
            op_sb: begin
                case (eff_addr[1:0])
                    2'd0:    write_data[31:24] = store_word[7:0];
                    2'd1:    write_data[23:16] = store_word[7:0];
                    2'd2:    write_data[15:8]  = store_word[7:0];
                    default: write_data[7:0]   = store_word[7:0];
                endcase
            end
            op_sh: begin
                if (eff_addr[1]) begin
                    write_data[15:0] = store_word[15:0];
                end else begin
                    write_data[31:16] = store_word[15:0];
                end
            end
            default: write_data = store_word;
        endcase
    end

endmodule

`default_nettype wire

/* logic/mips_cpu_harvard.sv */
`default_nettype none

module mips_cpu_harvard (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_enable,
    input  mips_isa_pkg::word_t instr_readdata,
    input  mips_isa_pkg::word_t data_readdata,
    output logic                active,
    output logic                data_read,
    output logic                data_write,
    output mips_isa_pkg::word_t register_v0,
    output mips_isa_pkg::word_t instr_address,
    output mips_isa_pkg::word_t data_address,
    output mips_isa_pkg::word_t data_writedata
);
    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;

    instr_t   instr;
    alu_out_t alu_out;
    logic     state;
    word_t    pc;
    word_t    delay_slot;
    word_t    next_target;
    word_t    hi;
    word_t    lo;
    word_t    reg_a;
    word_t    reg_b;
    word_t    load_data;
    word_t    wb_data;
    logic [4:0] wb_index;
    logic     executing;

    logic is_special, is_mult, is_mfhi, is_mflo, is_jr, is_jalr;
    logic is_load, is_store, is_partial_store, is_imm_alu, is_jimm, is_jal;
    logic reg_write;

    assign instr = instr_readdata;

    // decode
    assign is_special       = (instr.r.opcode == op_special);
    assign is_mult          = is_special && (instr.r.funct inside {fn_mult, fn_multu});
    assign is_mfhi          = is_special && (instr.r.funct == fn_mfhi);
    assign is_mflo          = is_special && (instr.r.funct == fn_mflo);
    assign is_jr            = is_special && (instr.r.funct == fn_jr);
    assign is_jalr          = is_special && (instr.r.funct == fn_jalr);
    assign is_load          = instr.i.opcode inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    assign is_store         = instr.i.opcode inside {op_sb, op_sh, op_sw};
    assign is_partial_store = instr.i.opcode inside {op_sb, op_sh};
    assign is_imm_alu       = instr.i.opcode inside {op_addiu, op_slti, op_sltiu, op_andi,
                                                     op_ori, op_xori, op_lui};
    assign is_jimm          = instr.j.opcode inside {op_j, op_jal};
    assign is_jal           = (instr.j.opcode == op_jal);

    assign reg_write = (is_special && !is_mult && !is_jr) || is_imm_alu || is_load || is_jal;
    assign wb_index  = is_jal ? 5'd31 : (is_special ? instr.r.rd : instr.r.rt);
    assign executing = active && state;

    // writeback select
    always_comb begin
        if (is_jal || is_jalr) begin
            wb_data = delay_slot + 32'd4;
        end else if (is_mfhi) begin
            wb_data = hi;
        end else if (is_mflo) begin
            wb_data = lo;
        end else if (is_load) begin
            wb_data = load_data;
        end else begin
            wb_data = alu_out.result;
        end
    end

    regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .write_enable (executing && reg_write),
        .read_index_a (instr.r.rs),
        .read_index_b (instr.r.rt),
        .write_index  (wb_index),
        .write_data   (wb_data),
        .read_data_a  (reg_a),
        .read_data_b  (reg_b),
        .register_v0  (register_v0)
    );

    alu u_alu (
        .op_a  (reg_a),
        .op_b  (reg_b),
        .instr (instr),
        .out   (alu_out)
    );

    mem_align u_mem_align (
        .instr      (instr),
        .eff_addr   (alu_out.eff_addr),
        .mem_word   (data_readdata),
        .store_word (reg_b),
        .load_data  (load_data),
        .write_data (data_writedata)
    );

    // target of the instruction after the delay slot
    always_comb begin
        if (alu_out.branch_taken) begin
            next_target = delay_slot + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
        end else if (is_jimm) begin
            next_target = {delay_slot[31:28], instr.j.target, 2'b00};
        end else if (is_jr || is_jalr) begin
            next_target = reg_a;
        end else begin
            next_target = delay_slot + 32'd4;
        end
    end

    // state 0 fetch, state 1 execute
    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                pc         <= reset_vector;
                delay_slot <= reset_vector + 32'd4;
                state      <= 1'b0;
                active     <= 1'b1;
            end else if (active) begin
                state <= !state;
                if (state) begin
                    pc         <= delay_slot;
                    delay_slot <= next_target;
                    if (pc == halt_address) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                hi <= '0;
                lo <= '0;
            end else if (executing && is_mult) begin
                hi <= alu_out.hi;
                lo <= alu_out.lo;
            end
        end
    end

    assign instr_address = pc;
    assign data_address  = {alu_out.eff_addr[31:2], 2'b00};

    // partial stores read the old word during fetch for the merge
    assign data_read  = !reset && active && (is_load || (is_partial_store && !state));
    assign data_write = !reset && executing && is_store;

endmodule

`default_nettype wire

/* logic/regfile.sv */
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic                clk_enable,
    input  logic                write_enable,
    input  logic [4:0]          read_index_a,
    input  logic [4:0]          read_index_b,
    input  logic [4:0]          write_index,
    input  mips_isa_pkg::word_t write_data,
    output mips_isa_pkg::word_t read_data_a,
    output mips_isa_pkg::word_t read_data_b,
    output mips_isa_pkg::word_t register_v0
);
    import mips_isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                for (int i = 0; i < 32; i++) begin
                    regs[i] <= '0;
                end
            end else if (write_enable && write_index != 5'd0) begin
                regs[write_index] <= write_data;
            end
        end
    end

    // $0 reads as zero regardless of contents
    assign read_data_a = (read_index_a == 5'd0) ? '0 : regs[read_index_a];
    assign read_data_b = (read_index_b == 5'd0) ? '0 : regs[read_index_b];
    assign register_v0 = regs[2];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mips -f filelist.f &&
./obj_dir/Vtb_mips | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
